//--- rtl/sram_queue_pkg.sv
// sizes, queue id and memory word layout shared by the SRAM queue controller
`default_nettype none

package sram_queue_pkg;

    ////////////////////////////////////////////////////////////
    // queue regions
    ////////////////////////////////////////////////////////////
    localparam int NUM_QUEUES   = 4;
    localparam int QID_WIDTH    = 2;
    localparam int ADDR_WIDTH   = 8;
    localparam int OFFSET_WIDTH = 6;
    localparam int QUEUE_WORDS  = 64;
    // full trips a few words early, leaves room for words in flight
    localparam int FULL_LEVEL   = QUEUE_WORDS - 5;
    localparam int COUNT_WIDTH  = 7;

    ////////////////////////////////////////////////////////////
    // data and chip lanes
    ////////////////////////////////////////////////////////////
    localparam int PAYLOAD_WIDTH        = 40;
    localparam int NUM_LANES            = 2;
    localparam int LANE_WIDTH           = 24;
    localparam int MEM_WIDTH            = NUM_LANES * LANE_WIDTH;
    localparam int LANE_FIFO_DEPTH_BITS = 2;

    typedef logic [QID_WIDTH-1:0] qid_t;

    // one memory word, seen as chip slices or as a tagged queue entry
    typedef union packed {
        logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lanes;
        struct packed {
            logic [MEM_WIDTH-PAYLOAD_WIDTH-QID_WIDTH-2:0] spare;
            logic                                         valid;
            qid_t                                         qid;
            logic [PAYLOAD_WIDTH-1:0]                     payload;
        } tagged_word;
    } mem_word_t;

endpackage

`default_nettype wire

//--- rtl/lane_fifo.sv
// fall-through FIFO holding the returned slices of one memory chip lane
`timescale 1ns/1ps
`default_nettype none

module lane_fifo
    import sram_queue_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [LANE_WIDTH-1:0] din,
    input  logic                  wr_en,
    input  logic                  rd_en,
    output logic [LANE_WIDTH-1:0] dout,
    output logic                  empty
);

    logic [LANE_WIDTH-1:0]           storage [2**LANE_FIFO_DEPTH_BITS];
    logic [LANE_FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [LANE_FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [LANE_FIFO_DEPTH_BITS:0]   fill;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            storage[wr_ptr] <= din;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            // push and pop together leave the fill alone
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // head shows through as soon as it is written
    assign dout  = storage[rd_ptr];
    assign empty = (fill == '0);

endmodule

`default_nettype wire

//--- rtl/return_merge.sv
// rejoins the skewed chip lanes into memory words and decodes the read data
`timescale 1ns/1ps
`default_nettype none

module return_merge
    import sram_queue_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  mem_word_t                lane_data,
    input  logic [NUM_LANES-1:0]     lane_valid,
    output logic [PAYLOAD_WIDTH-1:0] read_data,
    output qid_t                     read_data_queue_id,
    output logic                     read_data_valid
);

    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lane_head;
    logic [NUM_LANES-1:0]                 lane_empty;
    logic                                 pop;
    mem_word_t                            merged_word;

    // one buffer per chip, each chip answers on its own schedule
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        lane_fifo u_lane_fifo (
            .clk   (clk),
            .reset (reset),
            .din   (lane_data.lanes[i]),
            .wr_en (lane_valid[i]),
            .rd_en (pop),
            .dout  (lane_head[i]),
            .empty (lane_empty[i])
        );
    end

    // whole word present once every lane has its slice
    assign pop               = ~|lane_empty;
    assign merged_word.lanes = lane_head;

    assign read_data          = merged_word.tagged_word.payload;
    assign read_data_queue_id = merged_word.tagged_word.qid;
    assign read_data_valid    = pop && merged_word.tagged_word.valid;

endmodule

`default_nettype wire

//--- rtl/write_issue.sv
// write stage, takes producer words and issues them to the SRAM queue regions
`timescale 1ns/1ps
`default_nettype none

module write_issue
    import sram_queue_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write_data_valid,
    input  qid_t                     write_queue_id,
    input  logic [PAYLOAD_WIDTH-1:0] write_data,
    input  logic [NUM_QUEUES-1:0]    write_full,
    output logic                     write_taken,
    output logic                     mem_write,
    output logic [ADDR_WIDTH-1:0]    mem_write_addr,
    output mem_word_t                mem_write_word
);

    logic [OFFSET_WIDTH-1:0] wr_offset [NUM_QUEUES];
    logic                    write_phase;
    mem_word_t               take_word;

    // second half of the burst blocks a new take
    assign write_taken = write_data_valid && !write_phase && !write_full[write_queue_id];

    always_comb
    begin
        take_word                     = '0;
        take_word.tagged_word.valid   = 1'b1;
        take_word.tagged_word.qid     = write_queue_id;
        take_word.tagged_word.payload = write_data;
    end

    ////////////////////////////////////////////////////////////
    // burst phase and per-queue offsets
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            write_phase <= 1'b0;
            mem_write   <= 1'b0;
            for (int q = 0; q < NUM_QUEUES; q++)
                wr_offset[q] <= '0;
        end
        else
        begin
            write_phase <= write_taken;
            mem_write   <= write_taken;
            // offset wraps inside the region, queue bits never move
            if (write_taken)
                wr_offset[write_queue_id] <= wr_offset[write_queue_id] + 1'b1;
        end
    end

    // address and word toward the SRAM
    always_ff @(posedge clk)
    begin
        if (write_taken)
        begin
            mem_write_addr <= {write_queue_id, wr_offset[write_queue_id]};
            mem_write_word <= take_word;
        end
    end

endmodule

`default_nettype wire

//--- rtl/read_issue.sv
// read stage, issues SRAM read addresses for the queue the consumer picks
`timescale 1ns/1ps
`default_nettype none

module read_issue
    import sram_queue_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read_data_ready,
    input  qid_t                  read_queue_id,
    input  logic [NUM_QUEUES-1:0] read_empty,
    output logic                  read_taken,
    output logic                  mem_read,
    output logic [ADDR_WIDTH-1:0] mem_read_addr
);

    logic [OFFSET_WIDTH-1:0] rd_offset [NUM_QUEUES];
    logic                    read_phase;

    // only every other cycle, and never from an empty queue
    assign read_taken = read_data_ready && !read_phase && !read_empty[read_queue_id];

    ////////////////////////////////////////////////////////////
    // burst phase and per-queue offsets
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_phase <= 1'b0;
            mem_read   <= 1'b0;
            for (int q = 0; q < NUM_QUEUES; q++)
                rd_offset[q] <= '0;
        end
        else
        begin
            read_phase <= read_taken;
            mem_read   <= read_taken;
            if (read_taken)
                rd_offset[read_queue_id] <= rd_offset[read_queue_id] + 1'b1;
        end
    end

    // region bits come straight from the queue id
    always_ff @(posedge clk)
    begin
        if (read_taken)
            mem_read_addr <= {read_queue_id, rd_offset[read_queue_id]};
    end

endmodule

`default_nettype wire

//--- rtl/queue_occupancy.sv
// per-queue word counters that drive the empty and full flags
`timescale 1ns/1ps
`default_nettype none

module queue_occupancy
    import sram_queue_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  write_taken,
    input  qid_t                  write_queue_id,
    input  logic                  read_taken,
    input  qid_t                  read_queue_id,
    output logic [NUM_QUEUES-1:0] read_empty,
    output logic [NUM_QUEUES-1:0] write_full
);

    logic [COUNT_WIDTH-1:0] used [NUM_QUEUES];

    for (genvar i = 0; i < NUM_QUEUES; i++)
    begin : g_queue
        logic inc;
        logic dec;

        assign inc = write_taken && (write_queue_id == qid_t'(i));
        assign dec = read_taken && (read_queue_id == qid_t'(i));

        always_ff @(posedge clk)
        begin
            if (reset)
                used[i] <= '0;
            else if (inc && !dec)
                used[i] <= used[i] + 1'b1;
            else if (dec && !inc)
                used[i] <= used[i] - 1'b1;
        end

        ////////////////////////////////////////////////////////////
        // flags from the registered count
        ////////////////////////////////////////////////////////////
        assign read_empty[i] = (used[i] == '0);
        assign write_full[i] = (used[i] >= COUNT_WIDTH'(FULL_LEVEL));
    end

endmodule

`default_nettype wire

//--- rtl/sram_queue_ctrl.sv
// four packet queues kept in one external SRAM, write, read and return paths
`timescale 1ns/1ps
`default_nettype none

module sram_queue_ctrl
    import sram_queue_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write_data_valid,
    input  qid_t                     write_queue_id,
    input  logic [PAYLOAD_WIDTH-1:0] write_data,
    input  logic                     read_data_ready,
    input  qid_t                     read_queue_id,
    input  mem_word_t                lane_data,
    input  logic [NUM_LANES-1:0]     lane_valid,
    output logic                     write_taken,
    output logic                     read_taken,
    output logic [NUM_QUEUES-1:0]    write_full,
    output logic [NUM_QUEUES-1:0]    read_empty,
    output logic                     mem_write,
    output logic [ADDR_WIDTH-1:0]    mem_write_addr,
    output mem_word_t                mem_write_word,
    output logic                     mem_read,
    output logic [ADDR_WIDTH-1:0]    mem_read_addr,
    output logic [PAYLOAD_WIDTH-1:0] read_data,
    output qid_t                     read_data_queue_id,
    output logic                     read_data_valid
);

    ////////////////////////////////////////////////////////////
    // issue stages
    ////////////////////////////////////////////////////////////
    write_issue u_write_issue (
        .clk              (clk),
        .reset            (reset),
        .write_data_valid (write_data_valid),
        .write_queue_id   (write_queue_id),
        .write_data       (write_data),
        .write_full       (write_full),
        .write_taken      (write_taken),
        .mem_write        (mem_write),
        .mem_write_addr   (mem_write_addr),
        .mem_write_word   (mem_write_word)
    );

    read_issue u_read_issue (
        .clk             (clk),
        .reset           (reset),
        .read_data_ready (read_data_ready),
        .read_queue_id   (read_queue_id),
        .read_empty      (read_empty),
        .read_taken      (read_taken),
        .mem_read        (mem_read),
        .mem_read_addr   (mem_read_addr)
    );

    // bookkeeping, sees both takes in the same cycle
    queue_occupancy u_queue_occupancy (
        .clk            (clk),
        .reset          (reset),
        .write_taken    (write_taken),
        .write_queue_id (write_queue_id),
        .read_taken     (read_taken),
        .read_queue_id  (read_queue_id),
        .read_empty     (read_empty),
        .write_full     (write_full)
    );

    ////////////////////////////////////////////////////////////
    // return path
    ////////////////////////////////////////////////////////////
    return_merge u_return_merge (
        .clk                (clk),
        .reset              (reset),
        .lane_data          (lane_data),
        .lane_valid         (lane_valid),
        .read_data          (read_data),
        .read_data_queue_id (read_data_queue_id),
        .read_data_valid    (read_data_valid)
    );

endmodule

`default_nettype wire

//--- test/sram_model.sv
// behavioral SRAM with fixed read latency and a one-cycle skew between chip lanes
`timescale 1ns/1ps
`default_nettype none

module sram_model
    import sram_queue_pkg::*;
#(
    parameter int READ_LATENCY = 3
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_write,
    input  logic [ADDR_WIDTH-1:0] mem_write_addr,
    input  mem_word_t             mem_write_word,
    input  logic                  mem_read,
    input  logic [ADDR_WIDTH-1:0] mem_read_addr,
    output mem_word_t             lane_data,
    output logic [NUM_LANES-1:0]  lane_valid
);

    // lane i comes out READ_LATENCY + i cycles after mem_read
    localparam int STAGES = READ_LATENCY + NUM_LANES - 1;

    mem_word_t         mem [2**ADDR_WIDTH];
    logic [STAGES-1:0] pipe_valid;
    mem_word_t         pipe_word [STAGES];

    always @(posedge clk)
    begin
        if (mem_write)
            mem[mem_write_addr] <= mem_write_word;
    end

    ////////////////////////////////////////////////////////////
    // read delay line
    ////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        if (reset)
            pipe_valid <= '0;
        else
            pipe_valid <= {pipe_valid[STAGES-2:0], mem_read};
    end

    always @(posedge clk)
    begin
        pipe_word[0] <= mem[mem_read_addr];
        for (int i = 1; i < STAGES; i++)
            pipe_word[i] <= pipe_word[i-1];
    end

    // each chip taps the delay line at its own stage
    always_comb
    begin
        for (int l = 0; l < NUM_LANES; l++)
        begin
            lane_valid[l]      = pipe_valid[READ_LATENCY-1+l];
            lane_data.lanes[l] = pipe_word[READ_LATENCY-1+l].lanes[l];
        end
    end

endmodule

`default_nettype wire

//--- test/tb_sram_queue_ctrl.sv
// testbench replaying the case list on the SRAM queue controller against reference queues
`timescale 1ns/1ps
`default_nettype none

module tb_sram_queue_ctrl
    import sram_queue_pkg::*;
();

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 50;
    localparam int          READ_LATENCY = 3;
    localparam logic [15:0] LFSR_SEED    = 16'd18;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     write_data_valid;
    qid_t                     write_queue_id;
    logic [PAYLOAD_WIDTH-1:0] write_data;
    logic                     read_data_ready;
    qid_t                     read_queue_id;
    mem_word_t                lane_data;
    logic [NUM_LANES-1:0]     lane_valid;
    logic                     write_taken;
    logic                     read_taken;
    logic [NUM_QUEUES-1:0]    write_full;
    logic [NUM_QUEUES-1:0]    read_empty;
    logic                     mem_write;
    logic [ADDR_WIDTH-1:0]    mem_write_addr;
    mem_word_t                mem_write_word;
    logic                     mem_read;
    logic [ADDR_WIDTH-1:0]    mem_read_addr;
    logic [PAYLOAD_WIDTH-1:0] read_data;
    qid_t                     read_data_queue_id;
    logic                     read_data_valid;

    // one reference ring per DUT queue
    logic [PAYLOAD_WIDTH-1:0] ref_data [NUM_QUEUES][256];
    logic [7:0]               ref_head [NUM_QUEUES];
    logic [7:0]               ref_tail [NUM_QUEUES];
    int                       occ [NUM_QUEUES];
    int                       wr_off [NUM_QUEUES];
    int                       rd_off [NUM_QUEUES];
    qid_t                     ret_order [$];
    logic                     prev_wt;
    logic                     prev_rt;
    qid_t                     prev_wq;
    qid_t                     prev_rq;
    logic [PAYLOAD_WIDTH-1:0] prev_wdata;
    int                       check_errors = 0;
    int                       run_errors = 0;
    int                       n_written = 0;
    int                       n_read_back = 0;
    bit                       aborted = 1'b0;
    logic [15:0]              lfsr = LFSR_SEED;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sram_queue_ctrl UUT (
        .clk                (clk),
        .reset              (reset),
        .write_data_valid   (write_data_valid),
        .write_queue_id     (write_queue_id),
        .write_data         (write_data),
        .read_data_ready    (read_data_ready),
        .read_queue_id      (read_queue_id),
        .lane_data          (lane_data),
        .lane_valid         (lane_valid),
        .write_taken        (write_taken),
        .read_taken         (read_taken),
        .write_full         (write_full),
        .read_empty         (read_empty),
        .mem_write          (mem_write),
        .mem_write_addr     (mem_write_addr),
        .mem_write_word     (mem_write_word),
        .mem_read           (mem_read),
        .mem_read_addr      (mem_read_addr),
        .read_data          (read_data),
        .read_data_queue_id (read_data_queue_id),
        .read_data_valid    (read_data_valid)
    );

    sram_model #(.READ_LATENCY(READ_LATENCY)) u_sram_model (
        .clk            (clk),
        .reset          (reset),
        .mem_write      (mem_write),
        .mem_write_addr (mem_write_addr),
        .mem_write_word (mem_write_word),
        .mem_read       (mem_read),
        .mem_read_addr  (mem_read_addr),
        .lane_data      (lane_data),
        .lane_valid     (lane_valid)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_payload(output logic [PAYLOAD_WIDTH-1:0] p);
        p = '0;
        for (int b = 0; b < PAYLOAD_WIDTH; b++)
        begin
            lfsr = lfsr_step(lfsr);
            p    = {p[PAYLOAD_WIDTH-2:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("MISMATCH %s expected %h got %h at %0t ns", name, expected, actual, $time);
        check_errors++;
    endtask

    task automatic flag_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        check_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard sampling mid-cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin
        logic [NUM_QUEUES-1:0]            exp_empty;
        logic [NUM_QUEUES-1:0]            exp_full;
        logic                             exp_wt;
        logic                             exp_rt;
        logic [ADDR_WIDTH-1:0]            exp_addr;
        logic [PAYLOAD_WIDTH+QID_WIDTH:0] exp_tag;
        logic [PAYLOAD_WIDTH+QID_WIDTH:0] got_tag;
        qid_t                             exp_qid;
        logic [PAYLOAD_WIDTH-1:0]         exp_data;
        if (reset)
        begin
            for (int i = 0; i < NUM_QUEUES; i++)
            begin
                ref_head[i] = '0;
                ref_tail[i] = '0;
                occ[i]      = 0;
                wr_off[i]   = 0;
                rd_off[i]   = 0;
            end
            ret_order.delete();
            prev_wt = 1'b0;
            prev_rt = 1'b0;
        end
        else
        begin
            // flags reflect takes of earlier cycles only
            for (int i = 0; i < NUM_QUEUES; i++)
            begin
                exp_empty[i] = (occ[i] == 0);
                exp_full[i]  = (occ[i] >= FULL_LEVEL);
            end
            assert (read_empty == exp_empty)
            else report_mismatch("read_empty", 64'(exp_empty), 64'(read_empty));
            assert (write_full == exp_full)
            else report_mismatch("write_full", 64'(exp_full), 64'(write_full));
            assert (!(write_taken && prev_wt))
            else flag_error("write_taken high in two consecutive cycles");
            assert (!(read_taken && prev_rt))
            else flag_error("read_taken high in two consecutive cycles");

            // takes follow request, idle phase and predicted occupancy
            exp_wt = write_data_valid && !prev_wt && (occ[write_queue_id] < FULL_LEVEL);
            exp_rt = read_data_ready && !prev_rt && (occ[read_queue_id] > 0);
            assert (write_taken == exp_wt)
            else report_mismatch("write_taken", 64'(exp_wt), 64'(write_taken));
            assert (read_taken == exp_rt)
            else report_mismatch("read_taken", 64'(exp_rt), 64'(read_taken));

            // memory strobes follow their take by one cycle
            assert (mem_write == prev_wt)
            else report_mismatch("mem_write", 64'(prev_wt), 64'(mem_write));
            if (mem_write && prev_wt)
            begin
                exp_addr = {prev_wq, OFFSET_WIDTH'(wr_off[prev_wq])};
                exp_tag  = {1'b1, prev_wq, prev_wdata};
                got_tag  = {mem_write_word.tagged_word.valid, mem_write_word.tagged_word.qid,
                            mem_write_word.tagged_word.payload};
                assert (mem_write_addr == exp_addr)
                else report_mismatch("mem_write_addr", 64'(exp_addr), 64'(mem_write_addr));
                assert (got_tag == exp_tag)
                else report_mismatch("mem_write_word", 64'(exp_tag), 64'(got_tag));
                wr_off[prev_wq] = (wr_off[prev_wq] + 1) % QUEUE_WORDS;
            end
            assert (mem_read == prev_rt)
            else report_mismatch("mem_read", 64'(prev_rt), 64'(mem_read));
            if (mem_read && prev_rt)
            begin
                exp_addr = {prev_rq, OFFSET_WIDTH'(rd_off[prev_rq])};
                assert (mem_read_addr == exp_addr)
                else report_mismatch("mem_read_addr", 64'(exp_addr), 64'(mem_read_addr));
                rd_off[prev_rq] = (rd_off[prev_rq] + 1) % QUEUE_WORDS;
            end

            // words come back in issue order
            if (read_data_valid)
            begin
                assert (ret_order.size() != 0)
                else flag_error("read_data_valid with no read outstanding");
                if (ret_order.size() != 0)
                begin
                    exp_qid           = ret_order.pop_front();
                    exp_data          = ref_data[exp_qid][ref_head[exp_qid]];
                    ref_head[exp_qid] = ref_head[exp_qid] + 8'd1;
                    assert (read_data_queue_id == exp_qid)
                    else report_mismatch("read_data_queue_id", 64'(exp_qid),
                                         64'(read_data_queue_id));
                    assert (read_data == exp_data)
                    else report_mismatch("read_data", 64'(exp_data), 64'(read_data));
                    n_read_back++;
                end
            end

            if (read_taken)
            begin
                ret_order.push_back(read_queue_id);
                occ[read_queue_id]--;
            end
            if (write_taken)
            begin
                ref_data[write_queue_id][ref_tail[write_queue_id]] = write_data;
                ref_tail[write_queue_id] = ref_tail[write_queue_id] + 8'd1;
                occ[write_queue_id]++;
                n_written++;
            end
            prev_wt    = write_taken;
            prev_wq    = write_queue_id;
            prev_wdata = write_data;
            prev_rt    = read_taken;
            prev_rq    = read_queue_id;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    task automatic write_words(input int q, input int n);
        logic [PAYLOAD_WIDTH-1:0] p;
        int                       idle;
        bit                       taken;
        bit                       blocked;
        bit                       full_seen;
        blocked = 1'b0;
        for (int k = 0; k < n && !aborted && !blocked; k++)
        begin
            next_payload(p);
            write_queue_id   = qid_t'(q);
            write_data       = p;
            write_data_valid = 1'b1;
            taken = 1'b0;
            idle  = 0;
            while (!taken && !aborted && !blocked)
            begin
                @(negedge clk);
                taken     = write_taken;
                full_seen = write_full[qid_t'(q)];
                @(posedge clk);
                #1;
                idle++;
                if (!taken && idle > WAIT_LIMIT)
                begin
                    // a full queue holds the producer so the rest of the words are dropped
                    if (full_seen)
                        blocked = 1'b1;
                    else
                    begin
                        $display("write to queue %0d stalled with the queue not full", q);
                        run_errors++;
                        aborted = 1'b1;
                    end
                end
            end
        end
        write_data_valid = 1'b0;
    endtask

    task automatic read_words(input int q, input int n);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        read_queue_id   = qid_t'(q);
        read_data_ready = 1'b1;
        while (got < n && !aborted)
        begin
            @(negedge clk);
            if (read_taken)
            begin
                got++;
                idle = 0;
            end
            else
                idle++;
            @(posedge clk);
            #1;
            if (idle > WAIT_LIMIT)
            begin
                $display("read from queue %0d stalled after %0d of %0d words", q, got, n);
                run_errors++;
                aborted = 1'b1;
            end
        end
        read_data_ready = 1'b0;
    endtask

    task automatic drain_returns();
        int waited;
        waited = 0;
        while (ret_order.size() != 0 && !aborted)
        begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("%0d read words never came back", ret_order.size());
                run_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    initial
    begin
        int         fd;
        string      line;
        logic [7:0] op;
        int         q;
        int         n;
        int         rq;
        reset            = 1'b1;
        write_data_valid = 1'b0;
        write_queue_id   = '0;
        write_data       = '0;
        read_data_ready  = 1'b0;
        read_queue_id    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // idle window with no request driven
        repeat (4) @(posedge clk);
        #1;
        fd = $fopen("test/queue_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open test/queue_cases.txt");
            run_errors++;
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                void'($sscanf(line, "%c %d %d %d", op, q, n, rq));
                case (op)
                    "W": write_words(q, n);
                    "R": read_words(q, n);
                    "B":
                    begin
                        fork
                            write_words(q, n);
                            read_words(rq, n);
                        join
                    end
                    default:
                    begin
                        $display("unknown operation in case file: %s", line);
                        run_errors++;
                    end
                endcase
                drain_returns();
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("%0d words written, %0d words read back, %0d check errors, %0d run errors",
                 n_written, n_read_back, check_errors, run_errors);
        if (check_errors == 0 && run_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/queue_cases.txt
# op queue count [read_queue]
# W writes count words, R reads count words, B writes queue and reads read_queue together
W 0 5
W 1 3
R 0 5
R 1 3
W 2 10
W 3 4
B 0 8 2
B 3 6 3
W 1 62
R 1 1
W 1 1
R 1 59
W 1 10
R 1 10
B 1 4 1
B 2 5 0
R 0 3
R 2 7
R 3 4

//--- files.f
rtl/sram_queue_pkg.sv
rtl/lane_fifo.sv
rtl/return_merge.sv
rtl/write_issue.sv
rtl/read_issue.sv
rtl/queue_occupancy.sv
rtl/sram_queue_ctrl.sv
test/sram_model.sv
test/tb_sram_queue_ctrl.sv

//--- Makefile
# Verilator build and run for the SRAM queue controller testbench
TOP = tb_sram_queue_ctrl

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
